// ==== common/rv_pkg.sv ====
package rv_pkg;

  localparam int xlen_c = 32;

  // major opcodes, bits [6:0] of the instruction word
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;

  // top bit is the funct7 alternate bit, low three bits are funct3
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SUB  = 4'b1000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_SRA  = 4'b1101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111
  } alu_op_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one instruction word, viewed in each base format
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } inst_u;

  typedef struct packed {
    inst_u             inst;
    logic [xlen_c-1:0] pc;
  } fetch_t;

  typedef struct packed {
    logic [xlen_c-1:0] op1;
    logic [xlen_c-1:0] op2;
    alu_op_e           alu_op;
    logic [2:0]        br_cond;   // branch funct3
    logic              is_branch;
    logic              is_jump;
    logic [xlen_c-1:0] jump_base;
    logic [xlen_c-1:0] imm;
    logic [xlen_c-1:0] pc;
    logic [4:0]        rd;
    logic              we;
    logic              illegal;
  } issue_t;

  typedef struct packed {
    logic [xlen_c-1:0] pc;
    logic [4:0]        rd;
    logic [xlen_c-1:0] wdata;
    logic              we;
    logic              br_taken;  // taken branches and all jumps
    logic [xlen_c-1:0] target;
    logic              illegal;
  } retire_t;

endpackage

// ==== design/rv_regfile.sv ====
module rv_regfile (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [4:0]                raddr1_i,
  input  logic [4:0]                raddr2_i,
  input  logic                      wen_i,
  input  logic [4:0]                waddr_i,
  input  logic [rv_pkg::xlen_c-1:0] wdata_i,
  input  logic                      set_busy_i,
  input  logic [4:0]                set_addr_i,
  output logic [rv_pkg::xlen_c-1:0] rdata1_o,
  output logic [rv_pkg::xlen_c-1:0] rdata2_o,
  output logic                      busy1_o,
  output logic                      busy2_o
);

  logic [rv_pkg::xlen_c-1:0] regs [1:31];  // x0 is not stored
  logic [31:0]               busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && waddr_i != 5'd0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // a pending writer marks its destination until the result is written back
  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= '0;
    end else begin
      if (wen_i) busy[waddr_i] <= 1'b0;
      // set comes last so a newer writer keeps the bit
      if (set_busy_i && set_addr_i != 5'd0) busy[set_addr_i] <= 1'b1;
    end
  end

  // no bypass here, a source with a pending write is never read
  assign rdata1_o = (raddr1_i == 5'd0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == 5'd0) ? '0 : regs[raddr2_i];

  assign busy1_o = busy[raddr1_i];
  assign busy2_o = busy[raddr2_i];

endmodule

// ==== idu/rv_idu.sv ====
module rv_idu (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  input  rv_pkg::fetch_t            in_i,
  output logic [4:0]                raddr1_o,
  output logic [4:0]                raddr2_o,
  input  logic [rv_pkg::xlen_c-1:0] rdata1_i,
  input  logic [rv_pkg::xlen_c-1:0] rdata2_i,
  input  logic                      busy1_i,
  input  logic                      busy2_i,
  output logic                      iss_valid_o,
  input  logic                      iss_ready_i,
  output rv_pkg::issue_t            iss_o,
  output logic                      set_busy_o,
  output logic [4:0]                set_addr_o
);

  rv_pkg::fetch_t            fetch_q;
  logic                      full_q;
  logic                      issue;
  logic [6:0]                opcode;
  logic [2:0]                funct3;
  logic                      alt;
  logic [rv_pkg::xlen_c-1:0] imm_i;
  logic [rv_pkg::xlen_c-1:0] imm_b;
  logic [rv_pkg::xlen_c-1:0] imm_u;
  logic [rv_pkg::xlen_c-1:0] imm_j;

  assign iss_valid_o = full_q && !busy1_i && !busy2_i;  // wait for older results
  assign issue       = iss_valid_o && iss_ready_i;
  assign in_ready_o  = !full_q || issue;

  always_ff @(posedge clk) begin
    if (rst) begin
      full_q <= 1'b0;
    end else if (in_ready_o) begin
      full_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) fetch_q <= in_i;
  end

  assign opcode   = fetch_q.inst.r_fmt.opcode;
  assign funct3   = fetch_q.inst.r_fmt.funct3;
  assign alt      = fetch_q.inst.r_fmt.funct7[5];
  assign raddr1_o = fetch_q.inst.r_fmt.rs1;
  assign raddr2_o = fetch_q.inst.r_fmt.rs2;

  assign imm_i = {{20{fetch_q.inst.i_fmt.imm_11_0[11]}}, fetch_q.inst.i_fmt.imm_11_0};
  assign imm_b = {{20{fetch_q.inst.b_fmt.imm_12}}, fetch_q.inst.b_fmt.imm_11,
                  fetch_q.inst.b_fmt.imm_10_5, fetch_q.inst.b_fmt.imm_4_1, 1'b0};
  assign imm_u = {fetch_q.inst.u_fmt.imm_31_12, 12'b0};
  assign imm_j = {{12{fetch_q.inst.j_fmt.imm_20}}, fetch_q.inst.j_fmt.imm_19_12,
                  fetch_q.inst.j_fmt.imm_11, fetch_q.inst.j_fmt.imm_10_1, 1'b0};

  always_comb begin
    iss_o        = '0;
    iss_o.alu_op = rv_pkg::ALU_ADD;
    iss_o.pc     = fetch_q.pc;
    iss_o.rd     = fetch_q.inst.r_fmt.rd;
    case (opcode)
      rv_pkg::OP_LUI: begin
        iss_o.op2 = imm_u;  // op1 stays zero
        iss_o.imm = imm_u;
        iss_o.we  = 1'b1;
      end
      rv_pkg::OP_AUIPC: begin
        iss_o.op1 = fetch_q.pc;
        iss_o.op2 = imm_u;
        iss_o.imm = imm_u;
        iss_o.we  = 1'b1;
      end
      rv_pkg::OP_JAL, rv_pkg::OP_JALR: begin
        // link value is pc + 4, target is formed in execute
        iss_o.op1       = fetch_q.pc;
        iss_o.op2       = 32'd4;
        iss_o.is_jump   = 1'b1;
        iss_o.jump_base = (opcode == rv_pkg::OP_JALR) ? rdata1_i : fetch_q.pc;
        iss_o.imm       = (opcode == rv_pkg::OP_JALR) ? imm_i : imm_j;
        iss_o.we        = 1'b1;
      end
      rv_pkg::OP_BRANCH: begin
        iss_o.op1       = rdata1_i;
        iss_o.op2       = rdata2_i;
        iss_o.br_cond   = funct3;
        iss_o.is_branch = 1'b1;
        iss_o.jump_base = fetch_q.pc;
        iss_o.imm       = imm_b;
      end
      rv_pkg::OP_IMM: begin
        iss_o.op1    = rdata1_i;
        iss_o.op2    = imm_i;  // shifts only look at the low 5 bits
        iss_o.imm    = imm_i;
        // only srai carries the alternate bit in the immediate
        iss_o.alu_op = rv_pkg::alu_op_e'({alt && funct3 == 3'b101, funct3});
        iss_o.we     = 1'b1;
      end
      rv_pkg::OP_REG: begin
        iss_o.op1    = rdata1_i;
        iss_o.op2    = rdata2_i;
        iss_o.alu_op = rv_pkg::alu_op_e'({alt && (funct3 == 3'b000 || funct3 == 3'b101),
                                          funct3});
        iss_o.we     = 1'b1;
      end
      default: begin
        iss_o.illegal = 1'b1;  // retires without a register write
      end
    endcase
  end

  assign set_busy_o = issue && iss_o.we;
  assign set_addr_o = iss_o.rd;

endmodule

// ==== exu/rv_exu.sv ====
module rv_exu (
  input  logic            clk,
  input  logic            rst,
  input  logic            iss_valid_i,
  output logic            iss_ready_o,
  input  rv_pkg::issue_t  iss_i,
  output logic            out_valid_o,
  input  logic            out_ready_i,
  output rv_pkg::retire_t out_o
);

  logic [rv_pkg::xlen_c-1:0] alu_res;
  logic [rv_pkg::xlen_c-1:0] sum;
  logic [4:0]                shamt;
  logic                      eq;
  logic                      lt;
  logic                      ltu;
  logic                      cond;
  rv_pkg::retire_t           ret_d;

  assign iss_ready_o = !out_valid_o || out_ready_i;
  assign shamt       = iss_i.op2[4:0];

  always_comb begin
    case (iss_i.alu_op)
      rv_pkg::ALU_ADD:  alu_res = iss_i.op1 + iss_i.op2;
      rv_pkg::ALU_SUB:  alu_res = iss_i.op1 - iss_i.op2;
      rv_pkg::ALU_SLL:  alu_res = iss_i.op1 << shamt;
      rv_pkg::ALU_SLT:  alu_res = {31'b0, lt};
      rv_pkg::ALU_SLTU: alu_res = {31'b0, ltu};
      rv_pkg::ALU_XOR:  alu_res = iss_i.op1 ^ iss_i.op2;
      rv_pkg::ALU_SRL:  alu_res = iss_i.op1 >> shamt;
      rv_pkg::ALU_SRA:  alu_res = $signed(iss_i.op1) >>> shamt;
      rv_pkg::ALU_OR:   alu_res = iss_i.op1 | iss_i.op2;
      rv_pkg::ALU_AND:  alu_res = iss_i.op1 & iss_i.op2;
      default:          alu_res = '0;
    endcase
  end

  assign eq  = iss_i.op1 == iss_i.op2;
  assign lt  = $signed(iss_i.op1) < $signed(iss_i.op2);
  assign ltu = iss_i.op1 < iss_i.op2;

  always_comb begin
    case (iss_i.br_cond)
      3'b000:  cond = eq;
      3'b001:  cond = !eq;
      3'b100:  cond = lt;
      3'b101:  cond = !lt;
      3'b110:  cond = ltu;
      3'b111:  cond = !ltu;
      default: cond = 1'b0;
    endcase
  end

  assign sum = iss_i.jump_base + iss_i.imm;

  always_comb begin
    ret_d          = '0;
    ret_d.pc       = iss_i.pc;
    ret_d.rd       = iss_i.rd;
    ret_d.we       = iss_i.we;
    ret_d.illegal  = iss_i.illegal;
    ret_d.wdata    = iss_i.is_branch ? '0 : alu_res;
    ret_d.br_taken = iss_i.is_jump || (iss_i.is_branch && cond);
    if (iss_i.is_jump) begin
      // bit 0 is already clear for jal since pc is word aligned
      ret_d.target = {sum[rv_pkg::xlen_c-1:1], 1'b0};
    end else if (iss_i.is_branch) begin
      ret_d.target = sum;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_o <= 1'b0;
    end else if (iss_ready_o) begin
      out_valid_o <= iss_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (iss_valid_i && iss_ready_o) out_o <= ret_d;  // held while out_ready_i is low
  end

endmodule

// ==== design/rv_core_slice.sv ====
module rv_core_slice (
  input  logic            clk,
  input  logic            rst,
  input  logic            in_valid_i,
  output logic            in_ready_o,
  input  rv_pkg::fetch_t  in_i,
  output logic            out_valid_o,
  input  logic            out_ready_i,
  output rv_pkg::retire_t out_o
);

  logic [4:0]                raddr1;
  logic [4:0]                raddr2;
  logic [rv_pkg::xlen_c-1:0] rdata1;
  logic [rv_pkg::xlen_c-1:0] rdata2;
  logic                      busy1;
  logic                      busy2;
  logic                      iss_valid;
  logic                      iss_ready;
  rv_pkg::issue_t            iss;
  logic                      set_busy;
  logic [4:0]                set_addr;
  logic                      wb_en;

  // write back on the retire transfer, x0 stays zero
  assign wb_en = out_valid_o && out_ready_i && out_o.we && (out_o.rd != 5'd0);

  rv_idu rv_idu_inst (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_i        (in_i),
    .raddr1_o    (raddr1),
    .raddr2_o    (raddr2),
    .rdata1_i    (rdata1),
    .rdata2_i    (rdata2),
    .busy1_i     (busy1),
    .busy2_i     (busy2),
    .iss_valid_o (iss_valid),
    .iss_ready_i (iss_ready),
    .iss_o       (iss),
    .set_busy_o  (set_busy),
    .set_addr_o  (set_addr)
  );

  rv_exu rv_exu_inst (
    .clk         (clk),
    .rst         (rst),
    .iss_valid_i (iss_valid),
    .iss_ready_o (iss_ready),
    .iss_i       (iss),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_o       (out_o)
  );

  rv_regfile rv_regfile_inst (
    .clk        (clk),
    .rst        (rst),
    .raddr1_i   (raddr1),
    .raddr2_i   (raddr2),
    .wen_i      (wb_en),
    .waddr_i    (out_o.rd),
    .wdata_i    (out_o.wdata),
    .set_busy_i (set_busy),
    .set_addr_i (set_addr),
    .rdata1_o   (rdata1),
    .rdata2_o   (rdata2),
    .busy1_o    (busy1),
    .busy2_o    (busy2)
  );

endmodule

// ==== sim/rv_ref_model.svh ====
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// architectural register state as seen by the model, x0 is never written
logic [31:0] shadow_regs [32];

function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
  case (f3)
    3'b000:  if (alt) return a - b;
             else return a + b;
    3'b001:  return a << b[4:0];
    3'b010:  return {31'b0, $signed(a) < $signed(b)};
    3'b011:  return {31'b0, a < b};
    3'b100:  return a ^ b;
    3'b101:  if (alt) return $signed(a) >>> b[4:0];  // arithmetic shift keeps the sign
             else return a >> b[4:0];
    3'b110:  return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
  case (f3)
    3'b000:  return a == b;
    3'b001:  return a != b;
    3'b100:  return $signed(a) < $signed(b);
    3'b101:  return $signed(a) >= $signed(b);
    3'b110:  return a < b;
    3'b111:  return a >= b;
    default: return 1'b0;
  endcase
endfunction

// executes one instruction in program order and returns what it should retire as
function automatic rv_pkg::retire_t execute_model(input rv_pkg::fetch_t f);
  logic [31:0]     w;
  logic [4:0]      rd;
  logic [2:0]      f3;
  logic [31:0]     a;
  logic [31:0]     b;
  logic [31:0]     imm_i;
  logic [31:0]     imm_b;
  logic [31:0]     imm_u;
  logic [31:0]     imm_j;
  rv_pkg::retire_t r;
  w     = f.inst;
  rd    = w[11:7];
  f3    = w[14:12];
  a     = shadow_regs[w[19:15]];
  b     = shadow_regs[w[24:20]];
  imm_i = {{20{w[31]}}, w[31:20]};
  imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
  imm_u = {w[31:12], 12'b0};
  imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
  r     = '0;
  r.pc  = f.pc;
  r.rd  = rd;  // branches and illegal words still report bits 11:7
  case (w[6:0])
    rv_pkg::OP_LUI: begin
      r.we    = 1'b1;
      r.wdata = imm_u;
    end
    rv_pkg::OP_AUIPC: begin
      r.we    = 1'b1;
      r.wdata = f.pc + imm_u;
    end
    rv_pkg::OP_JAL: begin
      r.we       = 1'b1;
      r.wdata    = f.pc + 32'd4;
      r.br_taken = 1'b1;
      r.target   = f.pc + imm_j;
    end
    rv_pkg::OP_JALR: begin
      r.we       = 1'b1;
      r.wdata    = f.pc + 32'd4;
      r.br_taken = 1'b1;
      r.target   = (a + imm_i) & ~32'd1;
    end
    rv_pkg::OP_BRANCH: begin
      r.br_taken = branch_taken(f3, a, b);
      r.target   = f.pc + imm_b;
    end
    rv_pkg::OP_IMM: begin
      r.we    = 1'b1;
      r.wdata = alu_result(f3, w[30] && f3 == 3'b101, a, imm_i);  // only srai uses bit 30
    end
    rv_pkg::OP_REG: begin
      r.we    = 1'b1;
      r.wdata = alu_result(f3, w[30], a, b);
    end
    default: r.illegal = 1'b1;
  endcase
  if (r.we && rd != 5'd0) shadow_regs[rd] = r.wdata;
  return r;
endfunction

`endif

// ==== sim/tb_rv_core_slice.sv ====
module tb_rv_core_slice;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int num_insts    = 600;
  localparam int clk_period   = 40;
  localparam int reset_cycles = 16;
  localparam int timeout_ns   = (num_insts * 20 + reset_cycles) * clk_period;

  logic            clk;
  logic            rst;
  logic            in_valid;
  logic            in_ready;
  rv_pkg::fetch_t  in_data;
  logic            out_valid;
  logic            out_ready;
  rv_pkg::retire_t out_data;

  int              seed = 32'h66a9;
  rv_pkg::fetch_t  inflight_q [$];  // accepted but not yet retired, oldest first
  int              sent;
  int              retired;
  logic            accepted;
  logic [31:0]     next_pc;

  `include "rv_ref_model.svh"

  rv_core_slice rv_core_slice_inst (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .in_i        (in_data),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .out_o       (out_data)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped at %0t", $time);
  endtask

  task automatic check_retire(input rv_pkg::retire_t exp, input rv_pkg::retire_t act,
                              input string name);
    if (act !== exp) begin
      fail_run($sformatf("FAIL %s: expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_flag(input logic exp, input logic act, input string name);
    if (act !== exp) begin
      fail_run($sformatf("FAIL %s: expected %b actual %b", name, exp, act));
    end
  endtask

  function automatic string kind_name(input logic [6:0] opc);
    case (opc)
      rv_pkg::OP_LUI:    return "lui";
      rv_pkg::OP_AUIPC:  return "auipc";
      rv_pkg::OP_JAL:    return "jal";
      rv_pkg::OP_JALR:   return "jalr";
      rv_pkg::OP_BRANCH: return "branch";
      rv_pkg::OP_IMM:    return "op_imm";
      rv_pkg::OP_REG:    return "op";
      default:           return "illegal";
    endcase
  endfunction

  function automatic logic [31:0] random_inst();
    logic [31:0] f;
    logic [31:0] x;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  sel;
    logic [2:0]  bf3;
    logic [6:0]  funct7;
    logic [6:0]  bad_op;
    f      = $random(seed);
    x      = $random(seed);
    rd     = {2'b00, f[2:0]};  // x0 to x7 keeps hazards frequent
    rs1    = {2'b00, f[5:3]};
    rs2    = {2'b00, f[8:6]};
    sel    = f[15:13];
    bf3    = (sel[2:1] == 2'b01) ? {2'b00, sel[0]} : sel;  // 010 and 011 are no branch
    funct7 = (sel == 3'b000 || sel == 3'b101) ? {1'b0, x[30], 5'b0} : 7'b0;
    case (f[17:16])
      2'd0:    bad_op = 7'b0000011;  // load
      2'd1:    bad_op = 7'b0100011;  // store
      2'd2:    bad_op = 7'b1110011;
      default: bad_op = 7'b0001111;
    endcase
    case (f[12:9])
      4'd0:                   return {x[31:12], rd, rv_pkg::OP_LUI};
      4'd1:                   return {x[31:12], rd, rv_pkg::OP_AUIPC};
      4'd2:                   return {x[31:12], rd, rv_pkg::OP_JAL};
      4'd3:                   return {x[31:20], rs1, 3'b000, rd, rv_pkg::OP_JALR};
      4'd4, 4'd5:             return {x[31:25], rs2, rs1, bf3, x[11:7], rv_pkg::OP_BRANCH};
      4'd6, 4'd7, 4'd8, 4'd9: begin
        if (sel == 3'b001) return {7'b0, x[24:20], rs1, sel, rd, rv_pkg::OP_IMM};
        else if (sel == 3'b101) return {funct7, x[24:20], rs1, sel, rd, rv_pkg::OP_IMM};
        else return {x[31:20], rs1, sel, rd, rv_pkg::OP_IMM};
      end
      4'd14:                  return {x[31:7], bad_op};
      default:                return {funct7, rs2, rs1, sel, rd, rv_pkg::OP_REG};
    endcase
  endfunction

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(timeout_ns);
    fail_run("watchdog expired because the run hung before all results retired");
  end

  initial begin
    logic [31:0]     r;
    rv_pkg::fetch_t  oldest;
    rv_pkg::retire_t exp;
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_data   = '0;
    out_ready = 1'b0;
    sent      = 0;
    retired   = 0;
    accepted  = 1'b0;
    next_pc   = 32'h0000_1000;
    foreach (shadow_regs[i]) shadow_regs[i] = '0;
    repeat (reset_cycles) @(posedge clk);
    #2;
    rst = 1'b0;
    @(negedge clk);
    check_flag(1'b0, out_valid, "reset out_valid");
    check_flag(1'b1, in_ready, "reset in_ready");

    while (retired < num_insts) begin
      @(posedge clk);
      #2;
      if (accepted) in_valid = 1'b0;
      accepted = 1'b0;
      r = $random(seed);
      if (!in_valid && sent < num_insts && r[1:0] != 2'b00) begin
        in_data  = {random_inst(), next_pc};
        in_valid = 1'b1;
        next_pc  = next_pc + 32'd4;
      end
      out_ready = (r[10:4] < 7'd90);  // low about 30% of the time
      // handshakes are sampled mid cycle and complete on the next rising edge
      @(negedge clk);
      if (out_valid && out_ready) begin
        if (inflight_q.size() == 0) begin
          fail_run("a result retired with no instruction outstanding");
        end else begin
          oldest = inflight_q.pop_front();
          exp    = execute_model(oldest);
          check_retire(exp, out_data,
                       $sformatf("%s #%0d", kind_name(oldest.inst.r_fmt.opcode), retired));
          retired++;
        end
      end
      if (in_valid && in_ready) begin
        inflight_q.push_back(in_data);
        sent++;
        accepted = 1'b1;
      end
    end

    // with nothing left to send, decode must be empty and no extra result may appear
    repeat (4) begin
      @(posedge clk);
      #2;
      in_valid  = 1'b0;
      out_ready = 1'b1;
      @(negedge clk);
      check_flag(1'b0, out_valid, "drained out_valid");
      check_flag(1'b1, in_ready, "drained in_ready");
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+sim
common/rv_pkg.sv
design/rv_regfile.sv
idu/rv_idu.sv
exu/rv_exu.sv
design/rv_core_slice.sv
sim/tb_rv_core_slice.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/100ps \
  -f vlog.f --top-module tb_rv_core_slice -o sim_tb
./obj_dir/sim_tb
